// ==== Makefile ====
# Verilator build and run of the byte-to-word buffer testbench

TOP    ?= byteWordBufferTb
SEED   ?= 11
LOG    ?= sim.log
VFLAGS ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) -GseedValue=$(SEED) -f project.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG) || \
	   ! grep -q "TEST PASS" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/byteWordBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module byteWordBuffer
    import fifoPkg::*;
(
    input  logic                 iClk,
    input  logic                 rstN,
    // byte producer
    input  logic [byteWidth-1:0] wrData,
    input  logic                 wrEn,
    output logic                 full,
    // word consumer
    input  logic                 rdEn,
    output logic                 empty,
    output logic [wordWidth-1:0] wordData,
    output logic                 wordValid
);

    // ------------------------------
    // internal nets
    // ------------------------------

    // controller to ram
    logic                 ramWrEn;
    logic [addrWidth-1:0] ramWrAddr;
    logic [byteWidth-1:0] ramWrData;
    logic [addrWidth-1:0] ramRdAddr;
    // ram to packer
    logic [byteWidth-1:0] ramRdData;
    // controller to packer
    logic                 byteValid;

    // pointers, flags and read valid
    fifoController u_fifoController (
        .iClk      (iClk),
        .rstN      (rstN),
        .wrData    (wrData),
        .wrEn      (wrEn),
        .rdEn      (rdEn),
        .full      (full),
        .empty     (empty),
        .byteValid (byteValid),
        .ramWrEn   (ramWrEn),
        .ramWrAddr (ramWrAddr),
        .ramWrData (ramWrData),
        .ramRdAddr (ramRdAddr)
    );

    // byte storage
    fifoRam u_fifoRam (
        .iClk   (iClk),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .rdAddr (ramRdAddr),
        .wrData (ramWrData),
        .rdData (ramRdData)
    );

    // pairs of bytes into words
    wordPacker u_wordPacker (
        .iClk      (iClk),
        .rstN      (rstN),
        .byteData  (ramRdData),
        .byteValid (byteValid),
        .wordData  (wordData),
        .wordValid (wordValid)
    );

endmodule

`default_nettype wire

// ==== hdl/fifoController.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifoController
    import fifoPkg::*;
(
    input  logic                 iClk,
    input  logic                 rstN,
    // producer side
    input  logic [byteWidth-1:0] wrData,
    input  logic                 wrEn,
    output logic                 full,
    // consumer side
    input  logic                 rdEn,
    output logic                 empty,
    output logic                 byteValid,
    // ram control
    output logic                 ramWrEn,
    output logic [addrWidth-1:0] ramWrAddr,
    output logic [byteWidth-1:0] ramWrData,
    output logic [addrWidth-1:0] ramRdAddr
);

    // ------------------------------
    // pointers and level
    // ------------------------------

    // next slot to write
    logic [addrWidth-1:0] wrPtr;
    // next slot to read
    logic [addrWidth-1:0] rdPtr;
    // read pointer one clock back
    // also the ram read address
    logic [addrWidth-1:0] rdPtrLast;

    // entries held modulo the pointer width
    logic [addrWidth-1:0] fillLevel;
    // slots still free before the overrun guard
    logic [addrWidth-1:0] freeSlots;
    // raw empty for read acceptance
    logic                 ptrEqual;

    // qualified strobes
    logic                 wrAccept;
    logic                 rdAccept;

    // ------------------------------
    // level and acceptance
    // ------------------------------

    always_comb
    begin
        fillLevel = wrPtr - rdPtr;
        freeSlots = addrWidth'(fifoDepth - 1) - fillLevel;
        ptrEqual  = (wrPtr == rdPtr);
        // overrun guard drops writes once 255 entries are held
        wrAccept  = wrEn && (fillLevel != addrWidth'(fifoDepth - 1));
        // reads while empty are ignored
        rdAccept  = rdEn && !ptrEqual;
    end

    // ------------------------------
    // write pointer
    // ------------------------------

    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
        end
        else if (wrAccept)
        begin
            wrPtr <= wrPtr + addrWidth'(1);
        end
    end

    // ------------------------------
    // read pointer
    // ------------------------------

    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            rdPtr     <= '0;
            rdPtrLast <= '0;
        end
        else
        begin
            if (rdAccept)
            begin
                rdPtr <= rdPtr + addrWidth'(1);
            end
            // delayed copy tracks the pointer every clock
            rdPtrLast <= rdPtr;
        end
    end

    // ------------------------------
    // flags
    // ------------------------------

    // full rises with fullMargin or fewer slots left
    // empty is the pointer compare delayed one clock
    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            full  <= 1'b0;
            empty <= 1'b1;
        end
        else
        begin
            full  <= (freeSlots <= addrWidth'(fullMargin));
            empty <= ptrEqual;
        end
    end

    // ------------------------------
    // read valid
    // ------------------------------

    // pointer moved last clock so the ram now registers that slot
    // two clocks from the accepted rdEn in total
    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            byteValid <= 1'b0;
        end
        else
        begin
            byteValid <= (rdPtr != rdPtrLast);
        end
    end

    // ------------------------------
    // ram drive
    // ------------------------------

    // write straight through on the accept strobe
    assign ramWrEn   = wrAccept;
    assign ramWrAddr = wrPtr;
    assign ramWrData = wrData;
    // read one clock behind the pointer to line up with byteValid
    assign ramRdAddr = rdPtrLast;

endmodule

`default_nettype wire

// ==== hdl/fifoPkg.sv ====
`default_nettype none

package fifoPkg;

    // ------------------------------
    // buffer geometry
    // ------------------------------

    // ram entries
    localparam int fifoDepth  = 256;
    // pointer width, log2 of depth
    localparam int addrWidth  = 8;
    // byte lane on both fifo ports
    localparam int byteWidth  = 8;
    // packed output word
    localparam int wordWidth  = 16;
    // free slots left when full rises
    localparam int fullMargin = 6;

    // ------------------------------
    // packer FSM
    // ------------------------------

    // packEmpty holds nothing, packHalf holds the upper byte
    typedef enum logic {
        packEmpty,
        packHalf
    } packState_t;

endpackage

`default_nettype wire

// ==== hdl/fifoRam.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifoRam
    import fifoPkg::*;
(
    input  logic                 iClk,
    input  logic                 wrEn,
    input  logic [addrWidth-1:0] wrAddr,
    input  logic [addrWidth-1:0] rdAddr,
    input  logic [byteWidth-1:0] wrData,
    output logic [byteWidth-1:0] rdData
);

    // ------------------------------
    // storage array
    // ------------------------------

    // one byte per entry, inferred as block ram
    logic [byteWidth-1:0] mem [fifoDepth];

    // ------------------------------
    // write port
    // ------------------------------

    // store on enable only
    always_ff @(posedge iClk)
    begin
        if (wrEn)
        begin
            mem[wrAddr] <= wrData;
        end
    end

    // ------------------------------
    // read port
    // ------------------------------

    // registered output, data one clock after the address
    // the controller never reads the slot being written
    always_ff @(posedge iClk)
    begin
        rdData <= mem[rdAddr];
    end

endmodule

`default_nettype wire

// ==== hdl/wordPacker.sv ====
`timescale 1ns/1ns
`default_nettype none

module wordPacker
    import fifoPkg::*;
(
    input  logic                 iClk,
    input  logic                 rstN,
    input  logic [byteWidth-1:0] byteData,
    input  logic                 byteValid,
    output logic [wordWidth-1:0] wordData,
    output logic                 wordValid
);

    // ------------------------------
    // state
    // ------------------------------

    packState_t           packState;
    packState_t           packNext;
    // first byte of the pair, upper half of the word
    logic [byteWidth-1:0] upperByte;

    // ------------------------------
    // next state
    // ------------------------------

    // advance only on a valid byte
    always_comb
    begin
        packNext = packState;
        if (byteValid)
        begin
            case (packState)
                packEmpty: packNext = packHalf;
                packHalf:  packNext = packEmpty;
                default:   packNext = packEmpty;
            endcase
        end
    end

    // ------------------------------
    // control registers
    // ------------------------------

    // wordValid pulses for one clock per completed pair
    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            packState <= packEmpty;
            wordValid <= 1'b0;
        end
        else
        begin
            packState <= packNext;
            wordValid <= byteValid && (packState == packHalf);
        end
    end

    // ------------------------------
    // payload
    // ------------------------------

    // first byte parked, second byte completes the word
    always_ff @(posedge iClk)
    begin
        if (byteValid && (packState == packEmpty))
        begin
            upperByte <= byteData;
        end
        if (byteValid && (packState == packHalf))
        begin
            wordData <= {upperByte, byteData};
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hdl/fifoPkg.sv
hdl/fifoRam.sv
hdl/fifoController.sv
hdl/wordPacker.sv
hdl/byteWordBuffer.sv
verif/tbClockGen.sv
verif/byteWordChecker.sv
verif/byteWordBuffer_asserts.sv
verif/byteWordBufferTb.sv

// ==== include/fifoDefs.svh ====
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// ------------------------------
// verification switches
// ------------------------------

// enables the bound controller checks
`define FIFO_ASSERT_ON

`endif

// ==== verif/byteWordBufferTb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "fifoDefs.svh"

module byteWordBufferTb
    import fifoPkg::*;
#(
    parameter int seedValue = 11
);

    logic                 iClk;
    logic                 rstN;
    logic [byteWidth-1:0] wrData;
    logic                 wrEn;
    logic                 rdEn;
    logic                 full;
    logic                 empty;
    logic [wordWidth-1:0] wordData;
    logic                 wordValid;
    // scoreboard state
    logic [byteWidth-1:0] byteQueue [$];
    logic                 expPush;
    logic [wordWidth-1:0] expWord;
    int                   modelLevel;
    int                   acceptedReads;
    int                   wordsPredicted;
    int                   errorCount;
    int                   wordsSeen;
    int                   topErrors;
    int                   timeoutCount;

    tbClockGen      u_tbClockGen (.iClk(iClk), .rstN(rstN));
    byteWordBuffer  u_byteWordBuffer (.*);
    byteWordChecker u_byteWordChecker (.*);

    // ------------------------------
    // reference model
    // ------------------------------

    // first byte of the pair goes to the upper half
    function automatic logic [wordWidth-1:0] packWord();
        logic [byteWidth-1:0] upper;
        logic [byteWidth-1:0] lower;
        upper = byteQueue.pop_front();
        lower = byteQueue.pop_front();
        return {upper, lower};
    endfunction

    // writes drop at 255 held and reads are ignored at zero
    always @(posedge iClk)
    begin : scoreboard
        bit wrOk;
        bit rdOk;
        wrOk = rstN && wrEn && (modelLevel != fifoDepth - 1);
        rdOk = rstN && rdEn && (modelLevel != 0);
        if (wrOk)
            byteQueue.push_back(wrData);
        expPush <= 1'b0;
        // an odd count so far means this read closes a pair
        if (rdOk && (acceptedReads % 2 == 1))
        begin
            expWord        <= packWord();
            expPush        <= 1'b1;
            wordsPredicted <= wordsPredicted + 1;
        end
        acceptedReads <= acceptedReads + int'(rdOk);
        modelLevel    <= modelLevel + int'(wrOk) - int'(rdOk);
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------

    task automatic reportTimeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        timeoutCount++;
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("** Error at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            topErrors++;
        end
    endtask

    // one write per clock with full ignored
    task automatic writeBytes(input int count);
        repeat (count)
        begin
            wrEn   <= 1'b1;
            wrData <= byteWidth'($urandom);
            @(posedge iClk);
        end
        wrEn <= 1'b0;
    endtask

    // read until the model is empty and then let words and empty settle
    task automatic drainFifo(input int extraCycles);
        int guard;
        guard = 0;
        rdEn <= 1'b1;
        do
        begin
            @(posedge iClk);
            guard++;
        end
        while (modelLevel != 0 && guard < 1000);
        if (modelLevel != 0)
            reportTimeout("the FIFO to drain");
        // reads against an empty FIFO
        repeat (extraCycles) @(posedge iClk);
        rdEn  <= 1'b0;
        guard = 0;
        do
        begin
            @(posedge iClk);
            guard++;
        end
        while ((!empty || wordsSeen != wordsPredicted) && guard < 50);
        if (!empty || wordsSeen != wordsPredicted)
            reportTimeout("the last words and empty");
    endtask

    // complete a half word left in the packer
    task automatic alignPacker();
        if (acceptedReads % 2 != 0)
        begin
            writeBytes(1);
            drainFifo(0);
        end
    endtask

    initial
    begin : stimulus
        int guard;
        int wordsBefore;
        void'($urandom(seedValue));
        wrEn   <= 1'b0;
        rdEn   <= 1'b0;
        wrData <= '0;
        guard = 0;
        while (rstN !== 1'b1 && guard < 20)
        begin
            @(posedge iClk);
            guard++;
        end
        if (rstN !== 1'b1)
            reportTimeout("reset release");
        // mixed traffic where the writer backs off on full
        repeat (400)
        begin
            wrEn   <= !full && ($urandom_range(2) != 0);
            wrData <= byteWidth'($urandom);
            rdEn   <= ($urandom_range(1) == 1);
            @(posedge iClk);
        end
        wrEn <= 1'b0;
        drainFifo(4);
        alignPacker();
        // overrun with 300 writes where only 255 fit
        wordsBefore = wordsSeen;
        writeBytes(300);
        checkValue("full", 1, int'(full));
        drainFifo(8);
        checkValue("wordValid count", 127, wordsSeen - wordsBefore);
        // byte 255 still parked in the packer
        alignPacker();
        // back-to-back reads over 20 stored bytes
        wordsBefore = wordsSeen;
        writeBytes(20);
        rdEn <= 1'b1;
        repeat (20) @(posedge iClk);
        rdEn <= 1'b0;
        drainFifo(0);
        checkValue("wordValid count", 10, wordsSeen - wordsBefore);
        topErrors += u_byteWordBuffer.u_fifoController.u_controllerAsserts.failCount;
        $display("run complete: %0d errors, %0d timeouts",
                 errorCount + topErrors, timeoutCount);
        if (errorCount + topErrors == 0 && timeoutCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/byteWordBuffer_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "fifoDefs.svh"

module byteWordBuffer_asserts (
    input logic iClk,
    input logic rstN,
    input logic rdAccept,
    input logic full,
    input logic empty,
    input logic byteValid
);

    // bumped by every failing property
    int failCount;

    // flags exclusive
    flagsExclusive: assert property (@(posedge iClk) disable iff (!rstN) !(full && empty))
    else
    begin
        failCount++;
        $error("full and empty are high together");
    end

    // ram read latency plus pointer delay
    readToValid: assert property (@(posedge iClk) disable iff (!rstN) rdAccept |-> ##2 byteValid)
    else
    begin
        failCount++;
        $error("byteValid missing two cycles after an accepted read");
    end

    // first clock out of reset
    emptyAfterReset: assert property (@(posedge iClk) $rose(rstN) |-> empty)
    else
    begin
        failCount++;
        $error("empty low in the first cycle after reset");
    end

endmodule

// controller internals reach the checks through the bound ports
bind fifoController byteWordBuffer_asserts u_controllerAsserts (
    .iClk      (iClk),
    .rstN      (rstN),
    .rdAccept  (rdAccept),
    .full      (full),
    .empty     (empty),
    .byteValid (byteValid)
);

`default_nettype wire

// ==== verif/byteWordChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

module byteWordChecker
    import fifoPkg::*;
(
    input  logic                 iClk,
    input  logic                 rstN,
    input  logic                 full,
    input  logic                 empty,
    input  logic                 wordValid,
    input  logic [wordWidth-1:0] wordData,
    // expected words from the scoreboard
    input  logic                 expPush,
    input  logic [wordWidth-1:0] expWord,
    input  int                   modelLevel,
    output int                   errorCount,
    output int                   wordsSeen
);

    // words predicted but not yet out of the DUT
    logic [wordWidth-1:0] expQueue [$];
    bit                   resetChecked;
    bit                   fullLast;

    function automatic int bitMismatch(input string name, input logic expected,
                                       input logic actual);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: %s expected %b, actual %b",
                     $time, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge iClk)
    begin : compare
        logic [wordWidth-1:0] expected;
        int                   newErrors;
        newErrors = 0;
        // ------------------------------
        // idle flags right after reset
        // ------------------------------
        if (rstN && !resetChecked)
        begin
            resetChecked <= 1'b1;
            newErrors += bitMismatch("empty", 1'b1, empty);
            newErrors += bitMismatch("full", 1'b0, full);
            newErrors += bitMismatch("wordValid", 1'b0, wordValid);
        end
        // push before pop, a word never arrives in its own push cycle
        if (rstN && expPush)
            expQueue.push_back(expWord);
        if (rstN && wordValid)
        begin
            wordsSeen <= wordsSeen + 1;
            if (expQueue.size() == 0)
            begin
                $display("** Error at %0t ns: wordValid pulsed with no word predicted", $time);
                newErrors++;
            end
            else
            begin
                expected = expQueue.pop_front();
                if (wordData !== expected)
                begin
                    $display("** Error at %0t ns: wordData expected 0x%04h, actual 0x%04h",
                             $time, expected, wordData);
                    newErrors++;
                end
            end
        end
        // level when full first shows, flag lags the level
        fullLast <= full;
        if (rstN && full && !fullLast &&
            (modelLevel < fifoDepth - 1 - fullMargin || modelLevel > fifoDepth - 1))
        begin
            $display("** Error at %0t ns: full rose at level %0d, expected %0d to %0d",
                     $time, modelLevel, fifoDepth - 1 - fullMargin, fifoDepth - 1);
            newErrors++;
        end
        errorCount <= errorCount + newErrors;
    end

endmodule

`default_nettype wire

// ==== verif/tbClockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClockGen (
    output logic iClk,
    output logic rstN
);

    // 20 ns period, toggles every half period
    initial
    begin
        iClk = 1'b0;
        forever
        begin
            #10 iClk = ~iClk;
        end
    end

    // reset low for the first four rising edges
    initial
    begin
        rstN <= 1'b0;
        repeat (4) @(posedge iClk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire
